/* design/pinmux_pkg.sv */
package pinmux_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int PAD_NUM  = 16;
  // Port B in bits 7:0, port D in bits 15:8
  localparam int GPIO_W   = 16;
  localparam int PWM_NUM  = 6;
  localparam int UART_NUM = 2;
  localparam int INTR_NUM = 2;

  // Wishbone byte address and data
  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  typedef logic [PAD_NUM-1:0]  pad_vec_t;
  typedef logic [GPIO_W-1:0]   gpio_vec_t;
  typedef logic [PWM_NUM-1:0]  pwm_vec_t;
  typedef logic [UART_NUM-1:0] uart_vec_t;
  typedef logic [INTR_NUM-1:0] intr_vec_t;
  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam wb_adr_t REG_GPIO_DIR   = 4'h0;
  localparam wb_adr_t REG_MULTI_FUNC = 4'h4;

  // Fields of the function select register
  localparam int FLD_PWM_LSB  = 0;
  localparam int FLD_INT_LSB  = 6;
  localparam int FLD_UART_LSB = 8;

  //////////////////////////////
  // Pad map
  //////////////////////////////

  // GPIO bit carried by each pad, pad 0 first
  localparam int PAD_GPIO_MAP [PAD_NUM] = '{
    8, 9, 10, 11, 12,  // D0 to D4
    6, 7,              // B6 B7, crystal pins
    13, 14, 15,        // D5 to D7
    0, 1, 2, 3, 4, 5   // B0 to B5
  };

  // Alternate function pads
  localparam int PAD_RXD [UART_NUM] = '{0, 2};
  localparam int PAD_TXD [UART_NUM] = '{1, 4};
  localparam int PAD_INT [INTR_NUM] = '{2, 3};
  localparam int PAD_PWM [PWM_NUM]  = '{3, 7, 8, 11, 12, 13};

endpackage

/* design/pinmux_cfg_regs.sv */
`timescale 1ns/1ps

module pinmux_cfg_regs (
  input  logic                  mclk_i,
  input  logic                  arst_n_i,
  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  pinmux_pkg::wb_adr_t   wb_adr_i,
  input  pinmux_pkg::wb_dat_t   wb_dat_i,
  input  logic [3:0]            wb_sel_i,
  output logic                  wb_ack_o,
  output pinmux_pkg::wb_dat_t   wb_dat_o,
  // Configuration towards the mux
  output pinmux_pkg::gpio_vec_t gpio_dir_o,
  output pinmux_pkg::pwm_vec_t  pwm_enb_o,
  output pinmux_pkg::intr_vec_t int_enb_o,
  output pinmux_pkg::uart_vec_t uart_enb_o
);
  import pinmux_pkg::*;

  logic    wb_req;
  logic    wr_en;
  wb_adr_t word_adr;
  wb_dat_t dir_img;
  wb_dat_t mf_img;
  wb_dat_t dir_wr;
  wb_dat_t mf_wr;
  wb_dat_t rd_data;

  // Keep old bytes where the select is low
  function automatic wb_dat_t merge_bytes(wb_dat_t cur, wb_dat_t wdat, logic [3:0] sel);
    wb_dat_t res;
    for (int b = 0; b < WB_DAT_W / 8; b++) begin
      res[8*b +: 8] = sel[b] ? wdat[8*b +: 8] : cur[8*b +: 8];
    end
    return res;
  endfunction

  // New request only while no ack is out
  assign wb_req   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en    = wb_req & wb_we_i;
  // Byte lanes ignored in decode
  assign word_adr = {wb_adr_i[WB_ADR_W-1:2], 2'b00};

  //////////////////////////////
  // Register images
  //////////////////////////////

  always_comb begin
    dir_img = '0;
    dir_img[GPIO_W-1:0] = gpio_dir_o;
    mf_img = '0;
    mf_img[FLD_PWM_LSB +: PWM_NUM]   = pwm_enb_o;
    mf_img[FLD_INT_LSB +: INTR_NUM]  = int_enb_o;
    mf_img[FLD_UART_LSB +: UART_NUM] = uart_enb_o;
  end

  assign dir_wr = merge_bytes(dir_img, wb_dat_i, wb_sel_i);
  assign mf_wr  = merge_bytes(mf_img, wb_dat_i, wb_sel_i);

  // Read mux, holes read zero
  always_comb begin
    case (word_adr)
      REG_GPIO_DIR:   rd_data = dir_img;
      REG_MULTI_FUNC: rd_data = mf_img;
      default:        rd_data = '0;
    endcase
  end

  //////////////////////////////
  // Ack and registers
  //////////////////////////////

  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o   <= 1'b0;
      gpio_dir_o <= '0;
      pwm_enb_o  <= '0;
      int_enb_o  <= '0;
      uart_enb_o <= '0;
    end else begin
      // Single cycle ack
      wb_ack_o <= wb_req;
      if (wr_en && word_adr == REG_GPIO_DIR) begin
        gpio_dir_o <= dir_wr[GPIO_W-1:0];
      end
      if (wr_en && word_adr == REG_MULTI_FUNC) begin
        pwm_enb_o  <= mf_wr[FLD_PWM_LSB +: PWM_NUM];
        int_enb_o  <= mf_wr[FLD_INT_LSB +: INTR_NUM];
        uart_enb_o <= mf_wr[FLD_UART_LSB +: UART_NUM];
      end
    end
  end

  // Read data valid with ack
  always_ff @(posedge mclk_i) begin
    if (wb_req) begin
      wb_dat_o <= rd_data;
    end
  end

  // Ack is a single pulse
  a_ack_pulse: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o);

  // Ack answers a request of the cycle before
  a_ack_req: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

/* design/pinmux_in_route.sv */
`timescale 1ns/1ps

module pinmux_in_route #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                  mclk_i,
  input  logic                  arst_n_i,
  // Raw pad levels, asynchronous
  input  pinmux_pkg::pad_vec_t  pad_in_i,
  input  pinmux_pkg::intr_vec_t int_enb_i,
  input  pinmux_pkg::uart_vec_t uart_enb_i,
  output pinmux_pkg::gpio_vec_t gpio_in_o,
  output pinmux_pkg::uart_vec_t uart_rxd_o,
  output pinmux_pkg::intr_vec_t ext_intr_o
);
  import pinmux_pkg::*;

  // Stage 0 samples the pads
  pad_vec_t sync_q [SYNC_STAGES];
  pad_vec_t pad_sync;
  // Pads taken by an enabled UART receive
  pad_vec_t rx_owned;

  //////////////////////////////
  // Synchronizer
  //////////////////////////////

  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= pad_in_i;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign pad_sync = sync_q[SYNC_STAGES-1];

  //////////////////////////////
  // Routing
  //////////////////////////////

  // Scatter pads back to port bits
  always_comb begin
    gpio_in_o = '0;
    for (int p = 0; p < PAD_NUM; p++) begin
      gpio_in_o[PAD_GPIO_MAP[p]] = pad_sync[p];
    end
  end

  always_comb begin
    rx_owned   = '0;
    uart_rxd_o = '0;
    for (int u = 0; u < UART_NUM; u++) begin
      if (uart_enb_i[u]) begin
        rx_owned[PAD_RXD[u]] = 1'b1;
        uart_rxd_o[u]        = pad_sync[PAD_RXD[u]];
      end
    end
  end

  // RXD1 wins over INT0 on pad 2
  always_comb begin
    ext_intr_o = '0;
    for (int i = 0; i < INTR_NUM; i++) begin
      if (int_enb_i[i] && !rx_owned[PAD_INT[i]]) begin
        ext_intr_o[i] = pad_sync[PAD_INT[i]];
      end
    end
  end

endmodule

/* design/pinmux_out_sel.sv */
`timescale 1ns/1ps

module pinmux_out_sel (
  // GPIO data and direction
  input  pinmux_pkg::gpio_vec_t gpio_out_i,
  input  pinmux_pkg::gpio_vec_t gpio_dir_i,
  // Function enables
  input  pinmux_pkg::pwm_vec_t  pwm_enb_i,
  input  pinmux_pkg::intr_vec_t int_enb_i,
  input  pinmux_pkg::uart_vec_t uart_enb_i,
  // Alternate function outputs
  input  pinmux_pkg::pwm_vec_t  pwm_wfm_i,
  input  pinmux_pkg::uart_vec_t uart_txd_i,
  // Pad side, oen active low
  output pinmux_pkg::pad_vec_t  pad_out_o,
  output pinmux_pkg::pad_vec_t  pad_oen_o
);
  import pinmux_pkg::*;

  // Per pad result of each priority level
  pad_vec_t gpio_out;
  pad_vec_t gpio_oen;

  //////////////////////////////
  // GPIO level
  //////////////////////////////

  // Gather port bits onto pads
  always_comb begin
    gpio_out = '0;
    gpio_oen = '1;
    for (int p = 0; p < PAD_NUM; p++) begin
      if (gpio_dir_i[PAD_GPIO_MAP[p]]) begin
        gpio_out[p] = gpio_out_i[PAD_GPIO_MAP[p]];
        gpio_oen[p] = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Function overrides
  //////////////////////////////

  // Lowest priority applied first
  // Later levels overwrite earlier ones
  always_comb begin
    pad_out_o = gpio_out;
    pad_oen_o = gpio_oen;

    // Interrupt pads turn into inputs
    for (int i = 0; i < INTR_NUM; i++) begin
      if (int_enb_i[i]) begin
        pad_out_o[PAD_INT[i]] = 1'b0;
        pad_oen_o[PAD_INT[i]] = 1'b1;
      end
    end

    // PWM waveform, always driven
    for (int k = 0; k < PWM_NUM; k++) begin
      if (pwm_enb_i[k]) begin
        pad_out_o[PAD_PWM[k]] = pwm_wfm_i[k];
        pad_oen_o[PAD_PWM[k]] = 1'b0;
      end
    end

    // UART receive pads are inputs
    for (int u = 0; u < UART_NUM; u++) begin
      if (uart_enb_i[u]) begin
        pad_out_o[PAD_RXD[u]] = 1'b0;
        pad_oen_o[PAD_RXD[u]] = 1'b1;
      end
    end

    // UART transmit on top
    for (int u = 0; u < UART_NUM; u++) begin
      if (uart_enb_i[u]) begin
        pad_out_o[PAD_TXD[u]] = uart_txd_i[u];
        pad_oen_o[PAD_TXD[u]] = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // No UART pad may shadow a PWM pad
  always_comb begin
    for (int k = 0; k < PWM_NUM; k++) begin
      if (pwm_enb_i[k]) begin
        assert (!pad_oen_o[PAD_PWM[k]])
          else $error("PWM %0d enabled but pad %0d not driven", k, PAD_PWM[k]);
      end
    end
  end

endmodule

/* design/pinmux_top.sv */
`timescale 1ns/1ps

module pinmux_top #(
  // Synchronizer depth on pad inputs
  parameter int SYNC_STAGES = 2
) (
  input  logic                  mclk_i,
  input  logic                  arst_n_i,
  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  pinmux_pkg::wb_adr_t   wb_adr_i,
  input  pinmux_pkg::wb_dat_t   wb_dat_i,
  input  logic [3:0]            wb_sel_i,
  output logic                  wb_ack_o,
  output pinmux_pkg::wb_dat_t   wb_dat_o,
  // Pads
  input  pinmux_pkg::pad_vec_t  pad_in_i,
  output pinmux_pkg::pad_vec_t  pad_out_o,
  output pinmux_pkg::pad_vec_t  pad_oen_o,
  // GPIO core side
  input  pinmux_pkg::gpio_vec_t gpio_out_i,
  output pinmux_pkg::gpio_vec_t gpio_in_o,
  // PWM timers
  input  pinmux_pkg::pwm_vec_t  pwm_wfm_i,
  output pinmux_pkg::pwm_vec_t  pwm_enb_o,
  // UARTs and interrupt controller
  input  pinmux_pkg::uart_vec_t uart_txd_i,
  output pinmux_pkg::uart_vec_t uart_rxd_o,
  output pinmux_pkg::intr_vec_t ext_intr_o
);
  import pinmux_pkg::*;

  gpio_vec_t gpio_dir;
  intr_vec_t int_enb;
  uart_vec_t uart_enb;

  // Configuration registers
  pinmux_cfg_regs u_cfg_regs (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_ack_o   (wb_ack_o),
    .wb_dat_o   (wb_dat_o),
    .gpio_dir_o (gpio_dir),
    .pwm_enb_o  (pwm_enb_o),
    .int_enb_o  (int_enb),
    .uart_enb_o (uart_enb)
  );

  // Pad inputs, synchronized then routed
  pinmux_in_route #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_in_route (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .pad_in_i   (pad_in_i),
    .int_enb_i  (int_enb),
    .uart_enb_i (uart_enb),
    .gpio_in_o  (gpio_in_o),
    .uart_rxd_o (uart_rxd_o),
    .ext_intr_o (ext_intr_o)
  );

  // Pad outputs, combinational
  pinmux_out_sel u_out_sel (
    .gpio_out_i (gpio_out_i),
    .gpio_dir_i (gpio_dir),
    .pwm_enb_i  (pwm_enb_o),
    .int_enb_i  (int_enb),
    .uart_enb_i (uart_enb),
    .pwm_wfm_i  (pwm_wfm_i),
    .uart_txd_i (uart_txd_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o)
  );

endmodule

/* sim/tb_pinmux_model.svh */
`ifndef TB_PINMUX_MODEL_SVH
`define TB_PINMUX_MODEL_SVH

// Implemented bits of each register
localparam wb_dat_t DIR_MASK = 32'h0000_FFFF;
localparam wb_dat_t MF_MASK  = 32'h0000_03FF;

// PWM channel on a pad, -1 for none
function automatic int pwm_chan(int p);
  case (p)
    3:       return 0;
    7:       return 1;
    8:       return 2;
    11:      return 3;
    12:      return 4;
    13:      return 5;
    default: return -1;
  endcase
endfunction

// One pad as {oen, out}, highest priority first
// mf bits 5:0 PWM, 7:6 interrupts, 9:8 UARTs
function automatic logic [1:0] pad_rule(int p, gpio_vec_t gout, wb_dat_t dir, wb_dat_t mf,
                                        pwm_vec_t wfm, uart_vec_t txd);
  int k;
  int g;
  k = pwm_chan(p);
  g = PAD_GPIO_MAP[p];
  if (p == 1 && mf[8]) return {1'b0, txd[0]};
  if (p == 4 && mf[9]) return {1'b0, txd[1]};
  // Receive pads
  if ((p == 0 && mf[8]) || (p == 2 && mf[9])) return 2'b10;
  if (k >= 0 && mf[k]) return {1'b0, wfm[k]};
  // Interrupt pads
  if ((p == 2 && mf[6]) || (p == 3 && mf[7])) return 2'b10;
  if (dir[g]) return {1'b0, gout[g]};
  return 2'b10;
endfunction

// All pads, oen in the upper half
function automatic logic [2*PAD_NUM-1:0] model_pads(gpio_vec_t gout, wb_dat_t dir,
                                                    wb_dat_t mf, pwm_vec_t wfm,
                                                    uart_vec_t txd);
  logic [2*PAD_NUM-1:0] r;
  logic [1:0]           b;
  for (int p = 0; p < PAD_NUM; p++) begin
    b = pad_rule(p, gout, dir, mf, wfm, txd);
    r[PAD_NUM+p] = b[1];
    r[p]         = b[0];
  end
  return r;
endfunction

function automatic gpio_vec_t model_gpio_in(pad_vec_t pad);
  gpio_vec_t g;
  g = '0;
  for (int p = 0; p < PAD_NUM; p++) begin
    g[PAD_GPIO_MAP[p]] = pad[p];
  end
  return g;
endfunction

// RXD0 on pad 0, RXD1 on pad 2
function automatic uart_vec_t model_rxd(pad_vec_t pad, wb_dat_t mf);
  return {mf[9] & pad[2], mf[8] & pad[0]};
endfunction

// INT0 loses pad 2 to RXD1
function automatic intr_vec_t model_intr(pad_vec_t pad, wb_dat_t mf);
  return {mf[7] & pad[3], mf[6] & ~mf[9] & pad[2]};
endfunction

function automatic wb_dat_t merge_write(wb_dat_t old, wb_dat_t dat, logic [3:0] sel);
  wb_dat_t keep;
  for (int b = 0; b < 4; b++) begin
    keep[8*b +: 8] = {8{~sel[b]}};
  end
  return (old & keep) | (dat & ~keep);
endfunction

function automatic wb_dat_t model_read(wb_adr_t adr, wb_dat_t dir, wb_dat_t mf);
  case (adr[3:2])
    2'd0:    return dir;
    2'd1:    return mf;
    default: return '0;
  endcase
endfunction

`endif

/* sim/tb_pinmux.sv */
`timescale 1ns/1ps

module tb_pinmux;
  import pinmux_pkg::*;

  localparam int SYNC_STAGES = 2;
  localparam int ACK_LIMIT   = 16;

  logic       mclk_i;
  logic       arst_n_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  wb_adr_t    wb_adr_i;
  wb_dat_t    wb_dat_i;
  logic [3:0] wb_sel_i;
  logic       wb_ack_o;
  wb_dat_t    wb_dat_o;
  pad_vec_t   pad_in_i;
  pad_vec_t   pad_out_o;
  pad_vec_t   pad_oen_o;
  gpio_vec_t  gpio_out_i;
  gpio_vec_t  gpio_in_o;
  pwm_vec_t   pwm_wfm_i;
  pwm_vec_t   pwm_enb_o;
  uart_vec_t  uart_txd_i;
  uart_vec_t  uart_rxd_o;
  intr_vec_t  ext_intr_o;

  // Expected register contents
  wb_dat_t dir_sh;
  wb_dat_t mf_sh;
  logic [2*PAD_NUM-1:0] exp_pads;
  int fail_cnt = 0;
  int test_cnt = 0;
  bit hung = 1'b0;

  `include "tb_pinmux_model.svh"

  pinmux_top #(.SYNC_STAGES(SYNC_STAGES)) u_dut (.*);

  initial begin
    mclk_i = 1'b0;
    forever #5 mclk_i = ~mclk_i;
  end

  function automatic void note_fail(string msg);
    fail_cnt++;
    $display("[FAIL] t=%0d ns: %s", $time, msg);
  endfunction

  //////////////////////////////
  // Model and checks
  //////////////////////////////

  // Write takes effect on the edge that raises ack
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_sh <= '0;
      mf_sh  <= '0;
    end else if (wb_cyc_i && wb_stb_i && wb_we_i && !wb_ack_o) begin
      if (wb_adr_i[3:2] == 2'd0) dir_sh <= merge_write(dir_sh, wb_dat_i, wb_sel_i) & DIR_MASK;
      if (wb_adr_i[3:2] == 2'd1) mf_sh <= merge_write(mf_sh, wb_dat_i, wb_sel_i) & MF_MASK;
    end
  end

  assign exp_pads = model_pads(gpio_out_i, dir_sh, mf_sh, pwm_wfm_i, uart_txd_i);

  a_pad_out: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    pad_out_o == exp_pads[PAD_NUM-1:0]) else note_fail("pad_out_o differs from model");
  a_pad_oen: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    pad_oen_o == exp_pads[2*PAD_NUM-1:PAD_NUM]) else note_fail("pad_oen_o differs from model");
  a_pwm_enb: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    pwm_enb_o == mf_sh[5:0]) else note_fail("pwm_enb_o differs from register");
  // Routed inputs see pads from SYNC_STAGES edges back
  a_gpio_in: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    gpio_in_o == model_gpio_in($past(pad_in_i, SYNC_STAGES)))
    else note_fail("gpio_in_o differs from model");
  a_rxd: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    uart_rxd_o == model_rxd($past(pad_in_i, SYNC_STAGES), mf_sh))
    else note_fail("uart_rxd_o differs from model");
  a_intr: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    ext_intr_o == model_intr($past(pad_in_i, SYNC_STAGES), mf_sh))
    else note_fail("ext_intr_o differs from model");
  a_ack_len: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o) else note_fail("ack held longer than one cycle");

  //////////////////////////////
  // Bus and stimulus
  //////////////////////////////

  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                           input logic [3:0] sel, output wb_dat_t rdat);
    int waited;
    waited = 0;
    rdat = '0;
    if (!hung) begin
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      wb_sel_i <= sel;
      do begin
        @(posedge mclk_i);
        waited++;
      end while (!wb_ack_o && waited < ACK_LIMIT);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      if (!wb_ack_o) begin
        hung = 1'b1;
        $display("Timeout: no Wishbone ack within %0d cycles, address %h", ACK_LIMIT, adr);
      end else begin
        rdat = wb_dat_o;
        // Request seen on one edge, ack seen on the next
        assert (waited == 2) else note_fail("ack did not follow the request by one cycle");
      end
    end
  endtask

  task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input logic [3:0] sel);
    wb_dat_t ignored;
    bus_cycle(1'b1, adr, dat, sel, ignored);
  endtask

  task automatic read_check(input wb_adr_t adr);
    wb_dat_t rdat;
    bus_cycle(1'b0, adr, '0, 4'hF, rdat);
    if (!hung) begin
      assert (rdat == model_read(adr, dir_sh, mf_sh))
        else note_fail($sformatf("read %h gave %h, expected %h", adr, rdat,
                                 model_read(adr, dir_sh, mf_sh)));
    end
  endtask

  task automatic drive_random(input int cycles);
    repeat (cycles) begin
      pad_in_i   <= pad_vec_t'($urandom);
      gpio_out_i <= gpio_vec_t'($urandom);
      pwm_wfm_i  <= pwm_vec_t'($urandom);
      uart_txd_i <= uart_vec_t'($urandom);
      @(posedge mclk_i);
    end
  endtask

  task automatic report_test(input string name, input int start);
    test_cnt++;
    if (fail_cnt == start) begin
      $display("Test %-16s ok", name);
    end else begin
      $display("Test %-16s %0d errors", name, fail_cnt - start);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic check_reset_state();
    assert (pad_oen_o == '1 && pad_out_o == '0) else note_fail("pads not idle after reset");
    read_check(REG_GPIO_DIR);
    read_check(REG_MULTI_FUNC);
  endtask

  task automatic check_register_access();
    bus_write(REG_GPIO_DIR, $urandom, 4'hF);
    read_check(REG_GPIO_DIR);
    // Only byte 1 may change
    bus_write(REG_GPIO_DIR, 32'hFFFF_FFFF, 4'b0010);
    read_check(REG_GPIO_DIR);
    bus_write(REG_MULTI_FUNC, 32'h0000_0155, 4'b0001);
    read_check(REG_MULTI_FUNC);
    bus_write(REG_MULTI_FUNC, 32'h0000_0300, 4'b0010);
    read_check(REG_MULTI_FUNC);
    // Holes in the map
    bus_write(4'h8, 32'hFFFF_FFFF, 4'hF);
    read_check(4'h8);
    read_check(4'hC);
    read_check(REG_GPIO_DIR);
    bus_write(REG_MULTI_FUNC, '0, 4'hF);
  endtask

  task automatic check_gpio_mode();
    repeat (4) begin
      bus_write(REG_GPIO_DIR, $urandom, 4'hF);
      drive_random(12);
    end
  endtask

  task automatic check_pwm_override();
    bus_write(REG_GPIO_DIR, 32'hFFFF, 4'hF);
    repeat (4) begin
      bus_write(REG_MULTI_FUNC, $urandom & 32'h3F, 4'hF);
      drive_random(10);
    end
  endtask

  task automatic check_uart_override();
    // Both UARTs over all PWM channels, then one at a time
    bus_write(REG_MULTI_FUNC, 32'h33F, 4'hF);
    drive_random(12);
    bus_write(REG_MULTI_FUNC, 32'h100, 4'hF);
    drive_random(8);
    bus_write(REG_MULTI_FUNC, 32'h200, 4'hF);
    drive_random(8);
  endtask

  task automatic check_intr_routing();
    bus_write(REG_MULTI_FUNC, 32'h0C0, 4'hF);
    drive_random(12);
    // UART 1 takes pad 2
    bus_write(REG_MULTI_FUNC, 32'h2C0, 4'hF);
    drive_random(12);
    // PWM 0 keeps pad 3 driven while INT1 listens
    bus_write(REG_MULTI_FUNC, 32'h1C9, 4'hF);
    drive_random(12);
  endtask

  initial begin
    int start;
    void'($urandom(5840));
    arst_n_i   <= 1'b0;
    wb_cyc_i   <= 1'b0;
    wb_stb_i   <= 1'b0;
    wb_we_i    <= 1'b0;
    wb_adr_i   <= '0;
    wb_dat_i   <= '0;
    wb_sel_i   <= '0;
    pad_in_i   <= '0;
    gpio_out_i <= '0;
    pwm_wfm_i  <= '0;
    uart_txd_i <= '0;
    repeat (4) @(posedge mclk_i);
    arst_n_i <= 1'b1;
    @(posedge mclk_i);

    start = fail_cnt;
    check_reset_state();
    report_test("reset_state", start);
    start = fail_cnt;
    check_register_access();
    report_test("register_access", start);
    start = fail_cnt;
    check_gpio_mode();
    report_test("gpio_mode", start);
    start = fail_cnt;
    check_pwm_override();
    report_test("pwm_override", start);
    start = fail_cnt;
    check_uart_override();
    report_test("uart_override", start);
    start = fail_cnt;
    check_intr_routing();
    report_test("intr_routing", start);

    // Let the last routed values drain
    repeat (SYNC_STAGES + 2) @(posedge mclk_i);
    $display("Tests run: %0d, failed checks: %0d, bus timeout: %0d", test_cnt, fail_cnt, hung);
    if (fail_cnt == 0 && !hung) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+sim
design/pinmux_pkg.sv
design/pinmux_cfg_regs.sv
design/pinmux_in_route.sv
design/pinmux_out_sel.sv
design/pinmux_top.sv
sim/tb_pinmux.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pinmux
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
